// ==== Makefile ====
# Verilator build and run for the MIPS-like core testbench

VERILATOR ?= verilator
TOP       ?= tbMipsCore
FILELIST  ?= vlog.f
BUILDDIR  ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILDDIR) -f $(FILELIST)

run: compile
	-./$(BUILDDIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== controlFsm.sv ====
`timescale 1ns/1ps

module controlFsm (
    input  logic clock,
    input  logic arstN,
    input  cpuPkg::instr_t instr,
    input  logic overflow,
    input  logic equal,
    input  logic multDone,
    output cpuPkg::ctrlWord_t ctrl,
    output logic retireValid,
    output logic halted,
    output cpuPkg::haltCause_e haltCause
);

    cpuPkg::ctrlState_e state;
    cpuPkg::ctrlState_e nextState;
    cpuPkg::ctrlWord_t nextCtrl;
    cpuPkg::haltCause_e nextCause;
    logic isR;

    assign isR = (instr.opcode == cpuPkg::opSpecial);

    // Word issued in the fetch state
    function automatic cpuPkg::ctrlWord_t fetchWord();
        cpuPkg::ctrlWord_t w;
        w = '0;
        w.pcWrite = 1'b1;
        w.pcSel = cpuPkg::pcSeq;
        return w;
    endfunction

    always_comb begin
        nextState = state;
        nextCtrl = '0;
        nextCause = haltCause;
        case (state)
            cpuPkg::stFetch: begin
                if (!ctrl.pcWrite) begin
                    // First cycle out of reset only primes the control word
                    nextCtrl = fetchWord();
                end else begin
                    nextState = cpuPkg::stIrLoad;
                    nextCtrl.irWrite = 1'b1;
                end
            end
            cpuPkg::stIrLoad: begin
                nextState = cpuPkg::stDecode;
                nextCtrl.operandLoad = 1'b1;
            end
            cpuPkg::stDecode: begin
                nextState = cpuPkg::stExecute;
                if (isR) begin
                    case (instr.funct)
                        cpuPkg::fnAdd: nextCtrl.aluOp = cpuPkg::aluAdd;
                        cpuPkg::fnSub: nextCtrl.aluOp = cpuPkg::aluSub;
                        cpuPkg::fnAnd: nextCtrl.aluOp = cpuPkg::aluAnd;
                        cpuPkg::fnSlt: nextCtrl.aluOp = cpuPkg::aluSlt;
                        default: nextCtrl.aluOp = cpuPkg::aluAdd;
                    endcase
                    nextCtrl.aluOutLoad = instr.funct inside {cpuPkg::fnAdd, cpuPkg::fnSub,
                                                              cpuPkg::fnAnd, cpuPkg::fnSlt};
                    nextCtrl.multStart = (instr.funct == cpuPkg::fnMult);
                end else if (instr.opcode inside {cpuPkg::opAddi, cpuPkg::opAddiu}) begin
                    nextCtrl.aluOp = cpuPkg::aluAdd;
                    nextCtrl.aluSrcImm = 1'b1;
                    nextCtrl.aluOutLoad = 1'b1;
                end
            end
            cpuPkg::stExecute: begin
                nextState = cpuPkg::stHalted;
                nextCause = cpuPkg::haltIllegal;
                if (overflow) begin
                    nextCause = cpuPkg::haltOverflow;
                end else if (isR) begin
                    case (instr.funct)
                        cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd, cpuPkg::fnSlt,
                        cpuPkg::fnMfhi, cpuPkg::fnMflo: begin
                            nextState = cpuPkg::stWriteback;
                            nextCause = haltCause;
                            nextCtrl.regWrite = 1'b1;
                            if (instr.funct == cpuPkg::fnMfhi) begin
                                nextCtrl.wbSel = cpuPkg::wbHi;
                            end else if (instr.funct == cpuPkg::fnMflo) begin
                                nextCtrl.wbSel = cpuPkg::wbLo;
                            end
                        end
                        cpuPkg::fnMult: begin
                            nextState = cpuPkg::stMultWait;
                            nextCause = haltCause;
                        end
                        cpuPkg::fnBreak: nextCause = cpuPkg::haltBreak;
                        default: nextCause = cpuPkg::haltIllegal;
                    endcase
                end else begin
                    case (instr.opcode)
                        cpuPkg::opAddi, cpuPkg::opAddiu: begin
                            nextState = cpuPkg::stWriteback;
                            nextCause = haltCause;
                            nextCtrl.regWrite = 1'b1;
                            nextCtrl.regDestRt = 1'b1;
                        end
                        cpuPkg::opBeq, cpuPkg::opBne: begin
                            nextState = cpuPkg::stBranch;
                            nextCause = haltCause;
                            nextCtrl.pcSel = cpuPkg::pcBranch;
                            nextCtrl.pcWrite = (instr.opcode == cpuPkg::opBeq) ? equal : !equal;
                        end
                        cpuPkg::opJump: begin
                            nextState = cpuPkg::stBranch;
                            nextCause = haltCause;
                            nextCtrl.pcSel = cpuPkg::pcJump;
                            nextCtrl.pcWrite = 1'b1;
                        end
                        default: nextCause = cpuPkg::haltIllegal;
                    endcase
                end
            end
            cpuPkg::stWriteback, cpuPkg::stBranch: begin
                nextState = cpuPkg::stFetch;
                nextCtrl = fetchWord();
            end
            cpuPkg::stMultWait: begin
                if (multDone) begin
                    nextState = cpuPkg::stFetch;
                    nextCtrl = fetchWord();
                end
            end
            default: nextState = cpuPkg::stHalted;
        endcase
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            state <= cpuPkg::stFetch;
            ctrl <= '0;
            haltCause <= cpuPkg::haltNone;
        end else begin
            state <= nextState;
            ctrl <= nextCtrl;
            haltCause <= nextCause;
        end
    end

    assign retireValid = (state == cpuPkg::stWriteback) || (state == cpuPkg::stBranch) ||
                         (state == cpuPkg::stMultWait && multDone);
    assign halted = (state == cpuPkg::stHalted);

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int multSteps = 32;

    typedef logic [dataWidth-1:0] word_t;
    typedef logic [regAddrWidth-1:0] regIdx_t;

    localparam word_t resetPc = '0;

    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opJump    = 6'b000010,
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opAddi    = 6'b001000,
        opAddiu   = 6'b001001
    } opcode_e;

    typedef enum logic [5:0] {
        fnAdd   = 6'b100000,
        fnSub   = 6'b100010,
        fnAnd   = 6'b100100,
        fnSlt   = 6'b101010,
        fnMfhi  = 6'b010000,
        fnMflo  = 6'b010010,
        fnMult  = 6'b011000,
        fnBreak = 6'b001101
    } funct_e;

    typedef struct packed {
        opcode_e opcode;
        regIdx_t rs;
        regIdx_t rt;
        regIdx_t rd;
        logic [4:0] shamt;
        funct_e funct;
    } instr_t;

    typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluSlt} aluOp_e;
    typedef enum logic [1:0] {pcSeq, pcBranch, pcJump} pcSel_e;
    typedef enum logic [1:0] {wbAlu, wbHi, wbLo} wbSel_e;

    typedef enum logic [3:0] {
        stFetch, stIrLoad, stDecode, stExecute, stWriteback,
        stMultWait, stBranch,
        stHalted
    } ctrlState_e;

    typedef enum logic [1:0] {haltNone, haltBreak, haltOverflow, haltIllegal} haltCause_e;

    typedef struct packed {
        logic pcWrite;
        pcSel_e pcSel;
        logic irWrite;
        logic operandLoad;
        aluOp_e aluOp;
        logic aluSrcImm;
        logic aluOutLoad;
        logic regWrite;
        logic regDestRt;
        wbSel_e wbSel;
        logic multStart;
    } ctrlWord_t;

    typedef struct packed {
        logic valid;
        word_t pc;
        logic regWrite;
        regIdx_t regIdx;
        word_t data;
    } retire_t;

endpackage

// ==== execUnit.sv ====
`timescale 1ns/1ps

module execUnit (
    input  logic clock,
    input  logic arstN,
    input  cpuPkg::ctrlWord_t ctrl,
    input  cpuPkg::instr_t instr,
    input  cpuPkg::word_t readDataA,
    input  cpuPkg::word_t readDataB,
    input  cpuPkg::word_t instrPc,
    output cpuPkg::word_t operandA,
    output cpuPkg::word_t operandB,
    output cpuPkg::word_t aluResult,
    output logic overflow,
    output logic equal
);

    cpuPkg::word_t immExt;
    cpuPkg::word_t srcB;
    cpuPkg::word_t aluValue;
    cpuPkg::word_t branchTarget;
    logic addOvf;
    logic subOvf;

    assign immExt = {{16{instr[15]}}, instr[15:0]};
    assign srcB = ctrl.aluSrcImm ? immExt : operandB;
    assign branchTarget = instrPc + 32'd4 + {immExt[29:0], 2'b00};

    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::aluSub: aluValue = operandA - srcB;
            cpuPkg::aluAnd: aluValue = operandA & srcB;
            cpuPkg::aluSlt: aluValue = {31'd0, $signed(operandA) < $signed(srcB)};
            default: aluValue = operandA + srcB;
        endcase
    end

    // Signed overflow from operand and result signs
    assign addOvf = (operandA[31] == srcB[31]) && (aluValue[31] != operandA[31]);
    assign subOvf = (operandA[31] != srcB[31]) && (aluValue[31] != operandA[31]);

    // ADDIU never traps
    assign overflow = ctrl.aluOutLoad && (instr.opcode != cpuPkg::opAddiu) &&
                      ((ctrl.aluOp == cpuPkg::aluAdd && addOvf) ||
                       (ctrl.aluOp == cpuPkg::aluSub && subOvf));
    assign equal = (operandA == operandB);

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            operandA <= '0;
            operandB <= '0;
            aluResult <= '0;
        end else begin
            if (ctrl.operandLoad) begin
                operandA <= readDataA;
                operandB <= readDataB;
                aluResult <= branchTarget;
            end else if (ctrl.aluOutLoad) begin
                aluResult <= aluValue;
            end
        end
    end

endmodule

// ==== fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit (
    input  logic clock,
    input  logic arstN,
    input  cpuPkg::ctrlWord_t ctrl,
    input  cpuPkg::word_t imemData,
    input  cpuPkg::word_t aluResult,
    output cpuPkg::word_t imemAddr,
    output cpuPkg::instr_t instr,
    output cpuPkg::word_t instrPc
);

    cpuPkg::word_t pc;
    cpuPkg::word_t nextPc;

    assign imemAddr = pc;

    // pc already holds the incremented value outside fetch
    always_comb begin
        case (ctrl.pcSel)
            cpuPkg::pcBranch: nextPc = aluResult;
            cpuPkg::pcJump: nextPc = {pc[31:28], instr[25:0], 2'b00};
            default: nextPc = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pc <= cpuPkg::resetPc;
            instrPc <= cpuPkg::resetPc;
            instr <= '0;
        end else begin
            if (ctrl.pcWrite) begin
                pc <= nextPc;
            end
            if (ctrl.pcWrite && ctrl.pcSel == cpuPkg::pcSeq) begin
                instrPc <= pc;
            end
            if (ctrl.irWrite) begin
                instr <= cpuPkg::instr_t'(imemData);
            end
        end
    end

endmodule

// ==== mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore (
    input  logic clock,
    input  logic arstN,
    output cpuPkg::word_t imemAddr,
    input  cpuPkg::word_t imemData,
    output cpuPkg::retire_t retire,
    output logic halted,
    output cpuPkg::haltCause_e haltCause
);

    cpuPkg::ctrlWord_t ctrl;
    cpuPkg::instr_t instr;
    cpuPkg::word_t instrPc;
    cpuPkg::word_t readDataA;
    cpuPkg::word_t readDataB;
    cpuPkg::word_t operandA;
    cpuPkg::word_t operandB;
    cpuPkg::word_t aluResult;
    cpuPkg::word_t hi;
    cpuPkg::word_t lo;
    cpuPkg::word_t writeData;
    cpuPkg::regIdx_t writeIdx;
    logic overflow;
    logic equal;
    logic multDone;
    logic retireValid;

    controlFsm controlFsm_i (
        .clock(clock), .arstN(arstN), .instr(instr), .overflow(overflow),
        .equal(equal), .multDone(multDone), .ctrl(ctrl), .retireValid(retireValid),
        .halted(halted), .haltCause(haltCause)
    );

    fetchUnit fetchUnit_i (
        .clock(clock), .arstN(arstN), .ctrl(ctrl), .imemData(imemData),
        .aluResult(aluResult), .imemAddr(imemAddr), .instr(instr), .instrPc(instrPc)
    );

    regFile regFile_i (
        .clock(clock), .arstN(arstN), .readIdxA(instr.rs), .readIdxB(instr.rt),
        .readDataA(readDataA), .readDataB(readDataB), .writeEn(ctrl.regWrite),
        .writeIdx(writeIdx), .writeData(writeData)
    );

    execUnit execUnit_i (
        .clock(clock), .arstN(arstN), .ctrl(ctrl), .instr(instr),
        .readDataA(readDataA), .readDataB(readDataB), .instrPc(instrPc),
        .operandA(operandA), .operandB(operandB), .aluResult(aluResult),
        .overflow(overflow), .equal(equal)
    );

    multUnit multUnit_i (
        .clock(clock), .arstN(arstN), .multStart(ctrl.multStart),
        .operandA(operandA), .operandB(operandB), .multDone(multDone),
        .hi(hi), .lo(lo)
    );

    assign writeIdx = ctrl.regDestRt ? instr.rt : instr.rd;

    always_comb begin
        case (ctrl.wbSel)
            cpuPkg::wbHi: writeData = hi;
            cpuPkg::wbLo: writeData = lo;
            default: writeData = aluResult;
        endcase
    end

    assign retire.valid = retireValid;
    assign retire.pc = instrPc;
    assign retire.regWrite = ctrl.regWrite;
    assign retire.regIdx = writeIdx;
    assign retire.data = writeData;

endmodule

// ==== mipsCore_props.sv ====
`timescale 1ns/1ps

module mipsCore_props (
    input logic clock,
    input logic arstN,
    input cpuPkg::ctrlWord_t ctrl,
    input cpuPkg::retire_t retire,
    input logic halted,
    input cpuPkg::haltCause_e haltCause
);

    int propFailures = 0;

    // Outputs quiet in reset and in the first cycle after it
    quietInReset: assert property (@(posedge clock)
        !arstN |-> !retire.valid && !halted && haltCause == cpuPkg::haltNone)
        else begin
            $error("retire or halt active during reset");
            propFailures++;
        end

    quietAfterReset: assert property (@(posedge clock)
        $rose(arstN) |=> !retire.valid && !halted && haltCause == cpuPkg::haltNone)
        else begin
            $error("retire or halt active right after reset");
            propFailures++;
        end

    multStartPulse: assert property (@(posedge clock) disable iff (!arstN)
        ctrl.multStart |=> !ctrl.multStart)
        else begin
            $error("multStart wider than one cycle");
            propFailures++;
        end

    irWriteAlone: assert property (@(posedge clock) disable iff (!arstN)
        ctrl.irWrite |-> !ctrl.pcWrite && !ctrl.regWrite)
        else begin
            $error("irWrite together with a PC or register write");
            propFailures++;
        end

endmodule

// ==== multUnit.sv ====
`timescale 1ns/1ps

module multUnit (
    input  logic clock,
    input  logic arstN,
    input  logic multStart,
    input  cpuPkg::word_t operandA,
    input  cpuPkg::word_t operandB,
    output logic multDone,
    output cpuPkg::word_t hi,
    output cpuPkg::word_t lo
);

    localparam int countWidth = $clog2(cpuPkg::multSteps);

    logic busy;
    logic [countWidth-1:0] count;
    logic [63:0] acc;
    logic [63:0] accNext;
    logic [63:0] mcand;
    logic [63:0] addend;
    cpuPkg::word_t mplier;
    logic lastStep;

    assign lastStep = (count == countWidth'(cpuPkg::multSteps - 1));
    assign addend = mplier[0] ? mcand : 64'd0;
    // Sign bit of the multiplier carries negative weight
    assign accNext = lastStep ? acc - addend : acc + addend;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            busy <= 1'b0;
            count <= '0;
            multDone <= 1'b0;
        end else begin
            multDone <= 1'b0;
            if (multStart) begin
                busy <= 1'b1;
                count <= countWidth'(1);
            end else if (busy) begin
                count <= count + 1'b1;
                if (lastStep) begin
                    busy <= 1'b0;
                    multDone <= 1'b1;
                end
            end
        end
    end

    // Step zero is folded into the start cycle
    always_ff @(posedge clock) begin
        if (multStart) begin
            acc <= operandB[0] ? {{32{operandA[31]}}, operandA} : 64'd0;
            mcand <= {{31{operandA[31]}}, operandA, 1'b0};
            mplier <= operandB >> 1;
        end else if (busy) begin
            acc <= accNext;
            mcand <= mcand << 1;
            mplier <= mplier >> 1;
            if (lastStep) begin
                {hi, lo} <= accNext;
            end
        end
    end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic clock,
    input  logic arstN,
    input  cpuPkg::regIdx_t readIdxA,
    input  cpuPkg::regIdx_t readIdxB,
    output cpuPkg::word_t readDataA,
    output cpuPkg::word_t readDataB,
    input  logic writeEn,
    input  cpuPkg::regIdx_t writeIdx,
    input  cpuPkg::word_t writeData
);

    localparam int numRegs = 2 ** cpuPkg::regAddrWidth;

    cpuPkg::word_t regs [numRegs];

    // Architectural state starts cleared
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeIdx != '0) begin
            regs[writeIdx] <= writeData;
        end
    end

    // Register zero is never written, so it reads zero
    assign readDataA = regs[readIdxA];
    assign readDataB = regs[readIdxB];

endmodule

// ==== tbMipsCore.sv ====
`timescale 1ns/1ps

module tbMipsCore;

    localparam int progLen = 64;
    localparam int cyclesPerInstr = 40;
    localparam int cycleMargin = 20;

    logic clock;
    logic arstN;
    cpuPkg::word_t imemAddr;
    cpuPkg::word_t imemData;
    cpuPkg::word_t lastAddr;
    cpuPkg::retire_t retire;
    logic halted;
    cpuPkg::haltCause_e haltCause;

    logic [31:0] lfsr;
    cpuPkg::word_t prog [progLen];
    int progWords;
    cpuPkg::retire_t expRetire [$];
    cpuPkg::haltCause_e expCause;
    cpuPkg::word_t expHaltPc;
    int testErrors;
    int retireCount;
    int passed;
    int failed;
    int cycles;
    int cycleLimit;
    int propErrors;

    mipsCore mipsCore_i (
        .clock(clock), .arstN(arstN), .imemAddr(imemAddr), .imemData(imemData),
        .retire(retire), .halted(halted), .haltCause(haltCause)
    );

    bind mipsCore mipsCore_props propsCheck_i (
        .clock(clock), .arstN(arstN), .ctrl(ctrl), .retire(retire),
        .halted(halted), .haltCause(haltCause)
    );

    always #50 clock = ~clock;

    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit drawn
    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int randReg();
        return int'(randBits(3));
    endfunction

    function automatic cpuPkg::word_t rType(cpuPkg::funct_e fn, int rs, int rt, int rd);
        return {cpuPkg::opSpecial, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic cpuPkg::word_t iType(cpuPkg::opcode_e op, int rs, int rt,
                                            logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic cpuPkg::word_t jWord(int idx);
        return {cpuPkg::opJump, 26'(idx)};
    endfunction

    function automatic cpuPkg::word_t memWord(cpuPkg::word_t addr);
        if (addr < 4 * progLen) begin
            return prog[addr[7:2]];
        end
        // Past the program an illegal opcode tagged with the address
        return {6'h3f, addr[25:0] ^ {20'd0, addr[31:26]}};
    endfunction

    // Memory answers on the falling edge with the previous cycle's address
    always @(negedge clock) begin
        imemData <= memWord(lastAddr);
        lastAddr <= imemAddr;
    end

    task automatic clearProgram();
        for (int i = 0; i < progLen; i++) begin
            prog[i] = rType(cpuPkg::fnBreak, 0, 0, 0);
        end
    endtask

    task automatic buildRandom(int count);
        int last;
        int kind;
        int off;
        clearProgram();
        last = 8 + count;
        for (int r = 1; r < 8; r++) begin
            prog[r-1] = iType(cpuPkg::opAddiu, 0, r,
                              randBits(1) ? 16'(randBits(16)) : 16'(randBits(2)));
        end
        // HI and LO get defined before any MFHI or MFLO
        prog[7] = rType(cpuPkg::fnMult, 1, 2, 0);
        for (int i = 8; i < last; i++) begin
            kind = int'(randBits(4)) % 12;
            off = int'(randBits(2));
            if (i + 1 + off > last) begin
                off = last - i - 1;
            end
            case (kind)
                0: prog[i] = rType(cpuPkg::fnAdd, randReg(), randReg(), randReg());
                1: prog[i] = rType(cpuPkg::fnSub, randReg(), randReg(), randReg());
                2: prog[i] = rType(cpuPkg::fnAnd, randReg(), randReg(), randReg());
                3: prog[i] = rType(cpuPkg::fnSlt, randReg(), randReg(), randReg());
                4: prog[i] = iType(cpuPkg::opAddi, randReg(), randReg(), 16'(randBits(16)));
                5: prog[i] = iType(cpuPkg::opAddiu, randReg(), randReg(), 16'(randBits(16)));
                6: prog[i] = iType(cpuPkg::opBeq, randReg(), randReg(), 16'(off));
                7: prog[i] = iType(cpuPkg::opBne, randReg(), randReg(), 16'(off));
                8: prog[i] = jWord(i + 1 + off);
                9: prog[i] = rType(cpuPkg::fnMult, randReg(), randReg(), 0);
                10: prog[i] = rType(cpuPkg::fnMfhi, 0, 0, randReg());
                default: prog[i] = rType(cpuPkg::fnMflo, 0, 0, randReg());
            endcase
        end
        progWords = last + 1;
    endtask

    // Taken BEQ skips one word and lands on BREAK
    task automatic loadBreakProgram();
        clearProgram();
        prog[0] = iType(cpuPkg::opAddiu, 0, 1, 16'h0003);
        prog[1] = iType(cpuPkg::opBeq, 1, 1, 16'h0001);
        prog[2] = iType(cpuPkg::opAddiu, 0, 2, 16'h0007);
        progWords = 4;
    endtask

    // Builds 0x7fffffff with wrapping ADDIU, then ADDI on it traps
    task automatic loadOverflowProgram();
        clearProgram();
        prog[0] = iType(cpuPkg::opAddiu, 0, 1, 16'h4000);
        prog[1] = rType(cpuPkg::fnMult, 1, 1, 0);
        prog[2] = rType(cpuPkg::fnMflo, 0, 0, 2);
        prog[3] = rType(cpuPkg::fnAdd, 2, 2, 3);
        prog[4] = rType(cpuPkg::fnAdd, 3, 3, 4);
        prog[5] = rType(cpuPkg::fnSub, 0, 4, 5);
        prog[6] = rType(cpuPkg::fnAdd, 5, 5, 6);
        prog[7] = iType(cpuPkg::opAddiu, 6, 7, 16'hffff);
        prog[8] = iType(cpuPkg::opAddi, 7, 8, 16'h0001);
        prog[9] = iType(cpuPkg::opAddiu, 0, 9, 16'h0001);
        progWords = 11;
    endtask

    task automatic loadIllegalProgram();
        clearProgram();
        prog[0] = iType(cpuPkg::opAddiu, 0, 1, 16'h0005);
        prog[1] = iType(cpuPkg::opBne, 1, 0, 16'h0001);
        prog[2] = iType(cpuPkg::opAddiu, 0, 2, 16'h0007);
        prog[3] = {6'd0, 5'd1, 5'd2, 5'd3, 5'd0, 6'b000001};
        progWords = 5;
    endtask

    // Architectural model that fills the expected retire queue
    function automatic int runModel();
        cpuPkg::word_t regs [32];
        cpuPkg::word_t hi;
        cpuPkg::word_t lo;
        cpuPkg::word_t pc;
        cpuPkg::word_t nextPc;
        cpuPkg::word_t a;
        cpuPkg::word_t b;
        cpuPkg::word_t imm;
        cpuPkg::word_t wVal;
        cpuPkg::regIdx_t wIdx;
        cpuPkg::instr_t ins;
        cpuPkg::retire_t rec;
        logic [63:0] prod;
        logic [32:0] sum;
        logic ovf;
        logic doWrite;
        int steps;
        expRetire.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        hi = '0;
        lo = '0;
        pc = cpuPkg::resetPc;
        steps = 0;
        expCause = cpuPkg::haltNone;
        while (expCause == cpuPkg::haltNone && steps < 4 * progLen) begin
            ins = cpuPkg::instr_t'(memWord(pc));
            a = regs[ins.rs];
            b = regs[ins.rt];
            imm = {{16{ins[15]}}, ins[15:0]};
            nextPc = pc + 32'd4;
            wIdx = ins.rd;
            wVal = '0;
            doWrite = 1'b0;
            ovf = 1'b0;
            if (ins.opcode == cpuPkg::opSpecial) begin
                case (ins.funct)
                    cpuPkg::fnAdd, cpuPkg::fnSub: begin
                        if (ins.funct == cpuPkg::fnAdd) begin
                            sum = {a[31], a} + {b[31], b};
                        end else begin
                            sum = {a[31], a} - {b[31], b};
                        end
                        ovf = sum[32] ^ sum[31];
                        wVal = sum[31:0];
                        doWrite = 1'b1;
                    end
                    cpuPkg::fnAnd: begin
                        wVal = a & b;
                        doWrite = 1'b1;
                    end
                    cpuPkg::fnSlt: begin
                        wVal = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        doWrite = 1'b1;
                    end
                    cpuPkg::fnMult: begin
                        prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                        hi = prod[63:32];
                        lo = prod[31:0];
                    end
                    cpuPkg::fnMfhi, cpuPkg::fnMflo: begin
                        wVal = (ins.funct == cpuPkg::fnMfhi) ? hi : lo;
                        doWrite = 1'b1;
                    end
                    cpuPkg::fnBreak: expCause = cpuPkg::haltBreak;
                    default: expCause = cpuPkg::haltIllegal;
                endcase
            end else begin
                wIdx = ins.rt;
                case (ins.opcode)
                    cpuPkg::opAddi: begin
                        sum = {a[31], a} + {imm[31], imm};
                        ovf = sum[32] ^ sum[31];
                        wVal = sum[31:0];
                        doWrite = 1'b1;
                    end
                    cpuPkg::opAddiu: begin
                        wVal = a + imm;
                        doWrite = 1'b1;
                    end
                    cpuPkg::opBeq: nextPc = (a == b) ? pc + 32'd4 + (imm << 2) : nextPc;
                    cpuPkg::opBne: nextPc = (a != b) ? pc + 32'd4 + (imm << 2) : nextPc;
                    cpuPkg::opJump: nextPc = {nextPc[31:28], ins[25:0], 2'b00};
                    default: expCause = cpuPkg::haltIllegal;
                endcase
            end
            if (ovf) begin
                expCause = cpuPkg::haltOverflow;
            end
            if (expCause != cpuPkg::haltNone) begin
                expHaltPc = pc;
            end else begin
                rec = '0;
                rec.valid = 1'b1;
                rec.pc = pc;
                rec.regWrite = doWrite;
                rec.regIdx = doWrite ? wIdx : '0;
                rec.data = doWrite ? wVal : '0;
                if (doWrite && wIdx != 0) begin
                    regs[wIdx] = wVal;
                end
                expRetire.push_back(rec);
                pc = nextPc;
            end
            steps++;
        end
        return expRetire.size();
    endfunction

    // Index and data only matter when the instruction writes a register
    task automatic checkRetire(cpuPkg::retire_t exp, cpuPkg::retire_t got);
        logic bad;
        bad = (got.pc !== exp.pc) || (got.regWrite !== exp.regWrite);
        if (exp.regWrite) begin
            bad = bad || (got.regIdx !== exp.regIdx) || (got.data !== exp.data);
        end
        if (bad) begin
            $display("[FAIL] %0d ns: retire pc %h wr %b r%0d=%h, expected pc %h wr %b r%0d=%h",
                     $time, got.pc, got.regWrite, got.regIdx, got.data,
                     exp.pc, exp.regWrite, exp.regIdx, exp.data);
            testErrors++;
        end
    endtask

    task automatic checkCause(cpuPkg::haltCause_e exp, cpuPkg::haltCause_e got);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: halt cause %s, expected %s", $time, got.name(), exp.name());
            testErrors++;
        end
    endtask

    task automatic checkWord(cpuPkg::word_t exp, cpuPkg::word_t got, string what);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            testErrors++;
        end
    endtask

    always @(negedge clock) begin
        if (retire.valid === 1'b1) begin
            retireCount++;
            if (expRetire.size() == 0) begin
                $display("Unexpected retire of pc %h at %0d ns, the model has none left",
                         retire.pc, $time);
                testErrors++;
            end else begin
                checkRetire(expRetire.pop_front(), retire);
            end
        end
    end

    // Watchdog counts only while the core runs
    always @(negedge clock) begin
        if (!halted) begin
            cycles = cycles + 1;
        end
        if (cycles >= cycleLimit) begin
            $display("Timeout: the core did not halt within %0d cycles", cycleLimit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic runTest(string name);
        int expected;
        expected = runModel();
        testErrors = 0;
        retireCount = 0;
        cycleLimit = cyclesPerInstr * progWords + cycleMargin;
        cycles = 0;
        arstN = 1'b0;
        repeat (3) @(negedge clock);
        arstN = 1'b1;
        @(negedge clock);
        while (!halted) begin
            @(negedge clock);
        end
        // Cause must hold while parked until the next reset
        repeat (8) begin
            @(negedge clock);
            if (!halted) begin
                $display("halted dropped without a reset at %0d ns", $time);
                testErrors++;
            end
            checkCause(expCause, haltCause);
        end
        checkWord(expHaltPc, retire.pc, "halt pc");
        if (expRetire.size() != 0) begin
            $display("%0d expected retires never arrived", expRetire.size());
            testErrors++;
        end
        if (testErrors == 0) begin
            passed++;
        end else begin
            failed++;
        end
        $display("%s: %s, %0d of %0d retires, cause %s", name,
                 (testErrors == 0) ? "passed" : "failed", retireCount, expected,
                 haltCause.name());
    endtask

    initial begin
        clock = 1'b0;
        arstN = 1'b0;
        imemData = '0;
        lastAddr = '0;
        lfsr = 32'h2a26bcfd;
        passed = 0;
        failed = 0;
        cycles = 0;
        cycleLimit = cyclesPerInstr * progLen + cycleMargin;
        buildRandom(24);
        runTest("random program 1");
        buildRandom(40);
        runTest("random program 2");
        buildRandom(32);
        runTest("random program 3");
        loadBreakProgram();
        runTest("break halt");
        loadOverflowProgram();
        runTest("overflow trap");
        loadIllegalProgram();
        runTest("illegal funct");
        propErrors = mipsCore_i.propsCheck_i.propFailures;
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d assertion failures",
                 passed + failed, passed, failed, propErrors);
        if (failed == 0 && propErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
cpuPkg.sv
regFile.sv
execUnit.sv
multUnit.sv
fetchUnit.sv
controlFsm.sv
mipsCore.sv
mipsCore_props.sv
tbMipsCore.sv
